//--- keyPkg.sv
/*
 * Shared constants and types for the four-key click classifier.
 * Referred to by scoped name from every design file; timing is in milliseconds
 */
package keyPkg;

	// Key count and index width
	localparam int NUM_KEYS  = 4;
	localparam int KEY_IDX_W = 2;

	// Settling time after any accepted edge
	localparam int DEBOUNCE_MS = 10;

	// Window after a settled release in which a new press is a double click
	localparam int DCLICK_WINDOW_MS = 100;

	// Millisecond counters in the classifier, must hold DCLICK_WINDOW_MS
	localparam int MS_CNT_W = 7;

	// Board clock of 50 MHz
	localparam int CLK_PER_MS_DEFAULT = 50000;

	// Classification of one click
	typedef enum logic [1:0] {
		CLICK_NONE   = 2'd0,  // Nothing to report
		CLICK_SINGLE = 2'd1,  // Window expired without second press
		CLICK_DOUBLE = 2'd2   // Second press inside window
	} clickKind;

endpackage

//--- msTimebase.sv
/*
 * Millisecond prescaler. Emits a one-cycle tick every clkPerMs clocks,
 * the only place where the clock rate enters the design
 */
module msTimebase #(
	parameter int clkPerMs = 50000
) (
	input  logic CLOCK,
	input  logic RST_n,
	output logic msTick
);

	// Counter wide enough for clkPerMs - 1, also for tiny sim values
	logic [$clog2(clkPerMs + 1)-1:0] cnt;

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			cnt    <= $bits(cnt)'(clkPerMs - 1);
			msTick <= 1'b0;
		end else if (cnt == '0) begin
			cnt    <= $bits(cnt)'(clkPerMs - 1);  // Reload
			msTick <= 1'b1;
		end else begin
			cnt    <= cnt - 1'b1;
			msTick <= 1'b0;
		end
	end

endmodule

//--- keyDecode.sv
/*
 * Decode stage. Synchronizes every raw key through two flops and
 * registers the compare of the two as fall and rise pulses.
 * Keys are active low, so a fall is a press and a rise a release
 */
module keyDecode (
	input  logic                      CLOCK,
	input  logic                      RST_n,
	input  logic [keyPkg::NUM_KEYS-1:0] keyRaw,
	output logic [keyPkg::NUM_KEYS-1:0] keyFall,
	output logic [keyPkg::NUM_KEYS-1:0] keyRise
);

	logic [keyPkg::NUM_KEYS-1:0] sync1;  // First stage, may go metastable
	logic [keyPkg::NUM_KEYS-1:0] sync2;  // Second stage, older sample

	// Both stages read released after reset
	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			sync1 <= '1;
			sync2 <= '1;
		end else begin
			sync1 <= keyRaw;
			sync2 <= sync1;
		end
	end

	// Old high and new low is a press; pulse lands on third clock after the change
	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			keyFall <= '0;
			keyRise <= '0;
		end else begin
			keyFall <= sync2 & ~sync1;
			keyRise <= ~sync2 & sync1;
		end
	end

endmodule

//--- clickClassifier.sv
/*
 * Execute stage for one key. Debounces press and release in milliseconds,
 * times the double-click window and pulses single or double for one cycle.
 * Edge inputs come from keyDecode, msTick from msTimebase
 */
module clickClassifier (
	input  logic CLOCK,
	input  logic RST_n,
	input  logic msTick,
	input  logic keyFall,
	input  logic keyRise,
	output logic singleClick,
	output logic doubleClick
);

	typedef enum logic [3:0] {
		ST_IDLE,       // Wait for press
		ST_PRESS_DB,   // Press debounce
		ST_WAIT_REL,   // Wait for release
		ST_REL_DB,     // Release debounce
		ST_WINDOW,     // Double-click window
		ST_PULSE,      // Raise the result pulse
		ST_CLEAR,      // Drop the pulse
		ST_CHECK,      // Single ends here, double waits for release
		ST_WAIT_REL2,  // Release of the second press
		ST_REL2_DB     // Its debounce
	} clickState;

	clickState                   state;
	logic [keyPkg::MS_CNT_W-1:0] msCnt;  // Milliseconds in current step
	keyPkg::clickKind            kind;   // Held from window check to pulse

	logic dbDone;   // Last tick of a debounce interval
	logic winDone;  // Last tick of the window

	assign dbDone  = msTick && (msCnt == keyPkg::DEBOUNCE_MS - 1);
	assign winDone = msTick && (msCnt == keyPkg::DCLICK_WINDOW_MS - 1);

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			state       <= ST_IDLE;
			msCnt       <= '0;
			kind        <= keyPkg::CLICK_NONE;
			singleClick <= 1'b0;
			doubleClick <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (keyFall)
						state <= ST_PRESS_DB;
				end

				// Edges ignored while settling
				ST_PRESS_DB: begin
					if (dbDone) begin
						msCnt <= '0;
						state <= ST_WAIT_REL;
					end else if (msTick) begin
						msCnt <= msCnt + 1'b1;
					end
				end

				ST_WAIT_REL: begin
					if (keyRise)
						state <= ST_REL_DB;
				end

				ST_REL_DB: begin
					if (dbDone) begin
						msCnt <= '0;
						state <= ST_WINDOW;
					end else if (msTick) begin
						msCnt <= msCnt + 1'b1;
					end
				end

				// Press wins over expiry in the same cycle
				ST_WINDOW: begin
					if (keyFall) begin
						kind  <= keyPkg::CLICK_DOUBLE;
						msCnt <= '0;
						state <= ST_PULSE;
					end else if (winDone) begin
						kind  <= keyPkg::CLICK_SINGLE;
						msCnt <= '0;
						state <= ST_PULSE;
					end else if (msTick) begin
						msCnt <= msCnt + 1'b1;
					end
				end

				ST_PULSE: begin
					singleClick <= (kind == keyPkg::CLICK_SINGLE);
					doubleClick <= (kind == keyPkg::CLICK_DOUBLE);
					state       <= ST_CLEAR;
				end

				ST_CLEAR: begin
					singleClick <= 1'b0;
					doubleClick <= 1'b0;
					state       <= ST_CHECK;
				end

				// Second press still held after a double
				ST_CHECK: begin
					kind <= keyPkg::CLICK_NONE;
					if (kind == keyPkg::CLICK_DOUBLE)
						state <= ST_WAIT_REL2;
					else
						state <= ST_IDLE;
				end

				ST_WAIT_REL2: begin
					if (keyRise)
						state <= ST_REL2_DB;
				end

				ST_REL2_DB: begin
					if (dbDone) begin
						msCnt <= '0;
						state <= ST_IDLE;
					end else if (msTick) begin
						msCnt <= msCnt + 1'b1;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- clickResult.sv
/*
 * Result stage. Records click pulses of all keys as pending bits and
 * reports the lowest pending key once per cycle as an event strobe.
 * Single clicks toggle the key's light, double clicks its mode
 */
module clickResult (
	input  logic                          CLOCK,
	input  logic                          RST_n,
	input  logic [keyPkg::NUM_KEYS-1:0]   singleClick,
	input  logic [keyPkg::NUM_KEYS-1:0]   doubleClick,
	output logic [keyPkg::NUM_KEYS-1:0]   ledState,
	output logic [keyPkg::NUM_KEYS-1:0]   modeState,
	output logic                          eventStrobe,
	output logic [keyPkg::KEY_IDX_W-1:0]  eventKey,
	output keyPkg::clickKind              eventKind
);

	logic [keyPkg::NUM_KEYS-1:0]  pendSingle;
	logic [keyPkg::NUM_KEYS-1:0]  pendDouble;
	logic [keyPkg::NUM_KEYS-1:0]  anyPend;
	logic                         havePick;
	logic [keyPkg::KEY_IDX_W-1:0] pickIdx;
	logic                         pickDouble;  // Double goes first on a key
	logic [keyPkg::NUM_KEYS-1:0]  clrSingle;
	logic [keyPkg::NUM_KEYS-1:0]  clrDouble;

	assign anyPend  = pendSingle | pendDouble;
	assign havePick = |anyPend;

	// Priority pick, lowest index wins
	always_comb begin
		pickIdx = '0;
		for (int i = keyPkg::NUM_KEYS - 1; i >= 0; i--) begin
			if (anyPend[i])
				pickIdx = i[keyPkg::KEY_IDX_W-1:0];
		end
		pickDouble = pendDouble[pickIdx];
		clrSingle  = '0;
		clrDouble  = '0;
		if (havePick) begin
			if (pickDouble)
				clrDouble[pickIdx] = 1'b1;
			else
				clrSingle[pickIdx] = 1'b1;
		end
	end

	// New pulse wins over a clear of the same bit
	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			pendSingle <= '0;
			pendDouble <= '0;
		end else begin
			pendSingle <= (pendSingle & ~clrSingle) | singleClick;
			pendDouble <= (pendDouble & ~clrDouble) | doubleClick;
		end
	end

	// Report and toggle in the same clock
	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			eventStrobe <= 1'b0;
			eventKey    <= '0;
			eventKind   <= keyPkg::CLICK_NONE;
			ledState    <= '0;
			modeState   <= '0;
		end else begin
			eventStrobe <= havePick;
			eventKey    <= pickIdx;
			if (!havePick)
				eventKind <= keyPkg::CLICK_NONE;
			else if (pickDouble)
				eventKind <= keyPkg::CLICK_DOUBLE;
			else
				eventKind <= keyPkg::CLICK_SINGLE;
			ledState  <= ledState ^ clrSingle;
			modeState <= modeState ^ clrDouble;
		end
	end

endmodule

//--- keyClickTop.sv
/*
 * Top level of the click classifier. Wires the millisecond timebase,
 * the key decoder, one classifier per key and the result stage.
 * Set clkPerMs low for simulation
 */
module keyClickTop #(
	parameter int clkPerMs = keyPkg::CLK_PER_MS_DEFAULT
) (
	input  logic                         CLOCK,
	input  logic                         RST_n,
	input  logic [keyPkg::NUM_KEYS-1:0]  keyRaw,     // Pressed reads low
	output logic [keyPkg::NUM_KEYS-1:0]  ledState,
	output logic [keyPkg::NUM_KEYS-1:0]  modeState,
	output logic                         eventStrobe,
	output logic [keyPkg::KEY_IDX_W-1:0] eventKey,
	output keyPkg::clickKind             eventKind
);

	logic                        msTick;
	logic [keyPkg::NUM_KEYS-1:0] keyFall;
	logic [keyPkg::NUM_KEYS-1:0] keyRise;
	logic [keyPkg::NUM_KEYS-1:0] singleClick;
	logic [keyPkg::NUM_KEYS-1:0] doubleClick;

	msTimebase #(
		.clkPerMs(clkPerMs)
	) u_timebase (
		.CLOCK (CLOCK),
		.RST_n (RST_n),
		.msTick(msTick)
	);

	keyDecode u_decode (
		.CLOCK  (CLOCK),
		.RST_n  (RST_n),
		.keyRaw (keyRaw),
		.keyFall(keyFall),
		.keyRise(keyRise)
	);

	// One classifier per key, shared tick
	for (genvar g = 0; g < keyPkg::NUM_KEYS; g++) begin : g_key
		clickClassifier u_classifier (
			.CLOCK      (CLOCK),
			.RST_n      (RST_n),
			.msTick     (msTick),
			.keyFall    (keyFall[g]),
			.keyRise    (keyRise[g]),
			.singleClick(singleClick[g]),
			.doubleClick(doubleClick[g])
		);
	end

	clickResult u_result (
		.CLOCK      (CLOCK),
		.RST_n      (RST_n),
		.singleClick(singleClick),
		.doubleClick(doubleClick),
		.ledState   (ledState),
		.modeState  (modeState),
		.eventStrobe(eventStrobe),
		.eventKey   (eventKey),
		.eventKind  (eventKind)
	);

endmodule

//--- tb_keyClick.sv
/*
 * Testbench for keyClickTop at 10 clocks per millisecond.
 * Drives bounced key clicks, keeps a click-count model per key and
 * checks every strobe, light and mode with concurrent assertions
 */
module tb_keyClick;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PER_MS = 10;  // 1 ms is 100 ns
	localparam int NK         = keyPkg::NUM_KEYS;

	logic                          CLOCK;
	logic                          RST_n;
	logic [NK-1:0]                 keyRaw;
	logic [NK-1:0]                 ledState;
	logic [NK-1:0]                 modeState;
	logic                          eventStrobe;
	logic [keyPkg::KEY_IDX_W-1:0]  eventKey;
	keyPkg::clickKind              eventKind;

	integer seed = 5415;

	// Click model: expected from stimulus, seen from strobes
	int expSingle [NK] = '{default: 0};
	int expDouble [NK] = '{default: 0};
	int gotSingle [NK] = '{default: 0};
	int gotDouble [NK] = '{default: 0};

	logic                         prevStrobe = 1'b0;
	logic [keyPkg::KEY_IDX_W-1:0] prevKey    = '0;
	logic                         strobeExpected;  // Model still owes this click
	logic [NK-1:0]                ledModel;
	logic [NK-1:0]                modeModel;

	keyClickTop #(
		.clkPerMs(CLK_PER_MS)
	) u_dut (
		.CLOCK      (CLOCK),
		.RST_n      (RST_n),
		.keyRaw     (keyRaw),
		.ledState   (ledState),
		.modeState  (modeState),
		.eventStrobe(eventStrobe),
		.eventKey   (eventKey),
		.eventKind  (eventKind)
	);

	initial begin
		CLOCK = 1'b0;
		forever #5 CLOCK = ~CLOCK;
	end

	task automatic stopWithFailure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic reportMismatch(input string msg);
		$display("ERR at %0d ns: %s", $time, msg);
		stopWithFailure();
	endtask

	// Strobe bookkeeping, seen values update after the edge
	always @(posedge CLOCK) begin
		prevStrobe <= eventStrobe && RST_n;
		prevKey    <= eventKey;
		if (RST_n && eventStrobe) begin
			if (eventKind == keyPkg::CLICK_SINGLE)
				gotSingle[eventKey] <= gotSingle[eventKey] + 1;
			else if (eventKind == keyPkg::CLICK_DOUBLE)
				gotDouble[eventKey] <= gotDouble[eventKey] + 1;
		end
	end

	// Light and mode are the parity of reported clicks, this strobe included
	always_comb begin
		strobeExpected = 1'b0;
		for (int k = 0; k < NK; k++) begin
			ledModel[k]  = gotSingle[k][0];
			modeModel[k] = gotDouble[k][0];
		end
		if (eventStrobe) begin
			if (eventKind == keyPkg::CLICK_SINGLE) begin
				strobeExpected     = gotSingle[eventKey] < expSingle[eventKey];
				ledModel[eventKey] = ~ledModel[eventKey];
			end else if (eventKind == keyPkg::CLICK_DOUBLE) begin
				strobeExpected      = gotDouble[eventKey] < expDouble[eventKey];
				modeModel[eventKey] = ~modeModel[eventKey];
			end
		end
	end

	kindValid: assert property (@(posedge CLOCK) disable iff (!RST_n)
		eventStrobe |-> (eventKind != keyPkg::CLICK_NONE))
		else reportMismatch($sformatf("strobe on key %0d without click kind", eventKey));

	strobeMatchesModel: assert property (@(posedge CLOCK) disable iff (!RST_n)
		eventStrobe |-> strobeExpected)
		else reportMismatch($sformatf("unexpected %s strobe on key %0d",
			eventKind.name(), eventKey));

	statesMatchModel: assert property (@(posedge CLOCK) disable iff (!RST_n)
		(ledState == ledModel) && (modeState == modeModel))
		else reportMismatch($sformatf("lights %b modes %b, model %b %b",
			ledState, modeState, ledModel, modeModel));

	// Back-to-back strobes only come from a pending burst
	ascendingOrder: assert property (@(posedge CLOCK) disable iff (!RST_n)
		(eventStrobe && prevStrobe) |-> (eventKey > prevKey))
		else reportMismatch($sformatf("key %0d reported after key %0d", eventKey, prevKey));

	function automatic int totalExp();
		int sum = 0;
		for (int k = 0; k < NK; k++)
			sum += expSingle[k] + expDouble[k];
		return sum;
	endfunction

	function automatic int totalGot();
		int sum = 0;
		for (int k = 0; k < NK; k++)
			sum += gotSingle[k] + gotDouble[k];
		return sum;
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(posedge CLOCK);
		#1;  // Drive point after the edge
	endtask

	task automatic waitMs(input int ms);
		waitCycles(ms * CLK_PER_MS);
	endtask

	// Short glitches off the settled level, well inside one debounce
	task automatic bounceKey(input int k, input logic settled);
		int bursts;
		int len;
		bursts = 1 + ($unsigned($random(seed)) % 3);
		for (int b = 0; b < bursts; b++) begin
			len = 2 + ($unsigned($random(seed)) % 8);
			waitCycles(len);
			keyRaw[k] = ~settled;
			len = 1 + ($unsigned($random(seed)) % 6);
			waitCycles(len);
			keyRaw[k] = settled;
		end
	endtask

	task automatic pressKey(input int k, input bit withBounce);
		keyRaw[k] = 1'b0;  // Active low
		if (withBounce)
			bounceKey(k, 1'b0);
	endtask

	task automatic releaseKey(input int k, input bit withBounce);
		keyRaw[k] = 1'b1;
		if (withBounce)
			bounceKey(k, 1'b1);
	endtask

	task automatic singleClickOn(input int k, input bit withBounce);
		pressKey(k, withBounce);
		waitMs(30);
		releaseKey(k, withBounce);
		expSingle[k] = expSingle[k] + 1;  // Nothing follows, window will expire
	endtask

	task automatic doubleClickOn(input int k, input bit withBounce);
		pressKey(k, withBounce);
		waitMs(30);
		releaseKey(k, withBounce);
		waitMs(keyPkg::DEBOUNCE_MS + 40);  // 40 ms into the window
		pressKey(k, 1'b0);                 // Clean, a glitch would read as release
		expDouble[k] = expDouble[k] + 1;
		waitMs(30);
		releaseKey(k, withBounce);
		waitMs(keyPkg::DEBOUNCE_MS + 5);   // Classifier back in idle
	endtask

	task automatic waitForEvents(input int timeoutMs);
		int cycles;
		cycles = 0;
		while (totalGot() != totalExp()) begin
			if (cycles >= timeoutMs * CLK_PER_MS) begin
				$display("Timeout: saw %0d of %0d click events within %0d ms",
					totalGot(), totalExp(), timeoutMs);
				stopWithFailure();
			end else begin
				waitCycles(1);
				cycles++;
			end
		end
	endtask

	// Quiet spell, then lights and modes against model counts
	task automatic checkSettled(input string label);
		logic [NK-1:0] expLed;
		logic [NK-1:0] expMode;
		waitMs(20);
		for (int k = 0; k < NK; k++) begin
			expLed[k]  = expSingle[k][0];
			expMode[k] = expDouble[k][0];
		end
		assert (totalGot() == totalExp())
			else reportMismatch($sformatf("%s: %0d events, expected %0d",
				label, totalGot(), totalExp()));
		assert (ledState == expLed)
			else reportMismatch($sformatf("%s: lights %b, expected %b", label, ledState, expLed));
		assert (modeState == expMode)
			else reportMismatch($sformatf("%s: modes %b, expected %b", label, modeState, expMode));
	endtask

	task automatic randomClicks(input int count);
		int k;
		for (int i = 0; i < count; i++) begin
			k = $unsigned($random(seed)) % NK;
			if ($random(seed) & 1)
				doubleClickOn(k, 1'b1);
			else
				singleClickOn(k, 1'b1);
			waitForEvents(250);
		end
	endtask

	initial begin
		RST_n  = 1'b0;
		keyRaw = '1;  // All released
		repeat (16) @(posedge CLOCK);
		#1 RST_n = 1'b1;

		assert (!eventStrobe && eventKind == keyPkg::CLICK_NONE)
			else reportMismatch("event outputs not idle after reset");

		// Idle keys
		waitMs(50);
		checkSettled("idle");

		// Bounced single click
		singleClickOn(1, 1'b1);
		waitForEvents(200);
		checkSettled("single");

		// Second press 40 ms into the window
		doubleClickOn(2, 1'b1);
		waitForEvents(50);
		checkSettled("double");

		// Gap longer than the window gives two singles
		singleClickOn(0, 1'b1);
		waitMs(150);
		singleClickOn(0, 1'b1);
		waitForEvents(200);
		checkSettled("two singles");

		// Keys 3, 1 and 0 in lockstep
		keyRaw = keyRaw & ~4'b1011;
		waitMs(30);
		keyRaw = keyRaw | 4'b1011;
		expSingle[3] = expSingle[3] + 1;
		expSingle[1] = expSingle[1] + 1;
		expSingle[0] = expSingle[0] + 1;
		waitForEvents(200);
		checkSettled("simultaneous");

		randomClicks(16);
		waitMs(150);
		checkSettled("random bounces");

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- tb.f
keyPkg.sv
msTimebase.sv
keyDecode.sv
clickClassifier.sv
clickResult.sv
keyClickTop.sv
tb_keyClick.sv

//--- run.sh
#!/bin/sh
# Compile the click classifier testbench with Verilator and run it.
# Exits 0 only when the simulation output reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_keyClick \
	-Mdir obj_dir \
	-f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_keyClick)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
